// ==== rtl/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int ADDR_W     = 32;
	localparam int LINE_W     = 64;
	localparam int STRB_W     = 8;
	localparam int BYTE_W     = LINE_W / STRB_W;
	localparam int MISS_DEPTH = 4;   // entries per miss queue

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [LINE_W-1:0] line_t;
	typedef logic [STRB_W-1:0] strb_t;

	typedef struct packed {
		addr_t addr;
		line_t data;
	} fill_t;

	typedef struct packed {
		addr_t addr;
		line_t data;   // bytes that overwrite the returned line
		strb_t strb;
	} wr_miss_t;

endpackage

`default_nettype wire

// ==== rtl/cxl_pkg.sv ====
`default_nettype none

package cxl_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int TID_W = 4;

	typedef logic [TID_W-1:0] tid_t;

	// a read miss keeps its tid so the line can be returned to the ROB
	typedef struct packed {
		cache_pkg::addr_t addr;
		tid_t             tid;
	} rd_miss_t;

	typedef struct packed {
		tid_t             tid;
		cache_pkg::line_t data;
	} rob_entry_t;

endpackage

`default_nettype wire

// ==== rtl/fill_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface fill_if;
	import cache_pkg::*;

	logic  valid;
	logic  ready;
	addr_t addr;
	line_t data;

	modport source (   // miss handler side
		output valid,
		output addr,
		output data,
		input  ready
	);

	modport sink (   // arbiter side
		input  valid,
		input  addr,
		input  data,
		output ready
	);

endinterface

`default_nettype wire

// ==== rtl/miss_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module miss_fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = cache_pkg::MISS_DEPTH
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     push_valid_i,
	output logic     push_ready_o,
	input  payload_t push_data_i,
	input  logic     pop_i,
	output logic     empty_o,
	output payload_t pop_data_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic             push;
	logic             pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign push_ready_o = (count_q != CNT_W'(DEPTH));
	assign empty_o      = (count_q == '0);
	assign push         = push_valid_i && push_ready_o;
	assign pop          = pop_i && !empty_o;   // popping an empty queue does nothing
	assign pop_data_o   = mem[rd_ptr_q];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr_q] <= push_data_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= next_ptr(wr_ptr_q);
			end
			if (pop) begin
				rd_ptr_q <= next_ptr(rd_ptr_q);
			end
			case ({push, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/read_miss_handler.sv ====
`timescale 1ns/1ns
`default_nettype none

module read_miss_handler (
	input  logic                clk,
	input  logic                rst_n,
	// read completion channel
	input  logic                rsp_valid_i,
	output logic                rsp_ready_o,
	input  cache_pkg::line_t    rsp_data_i,
	// head of the read miss queue
	output logic                q_pop_o,
	input  logic                q_empty_i,
	input  cxl_pkg::rd_miss_t   q_data_i,
	// fill towards the arbiter
	fill_if.source              fill,
	// reorder buffer write port
	output logic                rob_we_o,
	input  logic                rob_full_i,
	output cxl_pkg::rob_entry_t rob_entry_o
);
	import cache_pkg::*;
	import cxl_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_FILL,
		S_ROB
	} state_t;

	state_t     state_q;
	state_t     state_d;
	fill_t      fill_q;
	rob_entry_t rob_q;
	logic       rsp_fire;

	// a completion is only taken when there is a miss waiting for it
	assign rsp_ready_o = (state_q == S_IDLE) && !q_empty_i;
	assign rsp_fire    = rsp_valid_i && rsp_ready_o;
	assign q_pop_o     = rsp_fire;   // oldest miss leaves with its completion

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE: begin
				if (rsp_fire) begin
					state_d = S_FILL;
				end
			end
			S_FILL: begin
				if (fill.ready) begin
					state_d = S_ROB;
				end
			end
			S_ROB: begin
				if (!rob_full_i) begin
					state_d = S_IDLE;
				end
			end
			default: state_d = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= S_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// fill and ROB payloads are latched here and held until their transfers
	always_ff @(posedge clk) begin
		if (rsp_fire) begin
			fill_q.addr <= q_data_i.addr;
			fill_q.data <= rsp_data_i;
			rob_q.tid   <= q_data_i.tid;
			rob_q.data  <= rsp_data_i;
		end
	end

	assign fill.valid  = (state_q == S_FILL);
	assign fill.addr   = fill_q.addr;
	assign fill.data   = fill_q.data;
	assign rob_we_o    = (state_q == S_ROB) && !rob_full_i;
	assign rob_entry_o = rob_q;

endmodule

`default_nettype wire

// ==== rtl/write_miss_handler.sv ====
`timescale 1ns/1ns
`default_nettype none

module write_miss_handler (
	input  logic                clk,
	input  logic                rst_n,
	// write completion channel
	input  logic                rsp_valid_i,
	output logic                rsp_ready_o,
	input  cache_pkg::line_t    rsp_data_i,
	// head of the write miss queue
	output logic                q_pop_o,
	input  logic                q_empty_i,
	input  cache_pkg::wr_miss_t q_data_i,
	// fill towards the arbiter
	fill_if.source              fill
);
	import cache_pkg::*;

	typedef enum logic {
		S_IDLE,
		S_FILL
	} state_t;

	state_t state_q;
	state_t state_d;
	fill_t  fill_q;
	line_t  merged;
	logic   rsp_fire;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// byte merge of the stored write data over the line from memory
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic line_t merge_bytes(
		input line_t mem_line,
		input line_t wr_line,
		input strb_t strb
	);
		line_t line;
		for (int b = 0; b < STRB_W; b++) begin
			if (strb[b]) begin
				line[b*BYTE_W +: BYTE_W] = wr_line[b*BYTE_W +: BYTE_W];
			end else begin
				line[b*BYTE_W +: BYTE_W] = mem_line[b*BYTE_W +: BYTE_W];
			end
		end
		return line;
	endfunction

	assign merged = merge_bytes(rsp_data_i, q_data_i.data, q_data_i.strb);

	assign rsp_ready_o = (state_q == S_IDLE) && !q_empty_i;
	assign rsp_fire    = rsp_valid_i && rsp_ready_o;
	assign q_pop_o     = rsp_fire;

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE: begin
				if (rsp_fire) begin
					state_d = S_FILL;
				end
			end
			S_FILL: begin
				if (fill.ready) begin
					state_d = S_IDLE;   // a write miss needs no ROB entry
				end
			end
			default: state_d = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= S_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_ff @(posedge clk) begin
		if (rsp_fire) begin
			fill_q.addr <= q_data_i.addr;
			fill_q.data <= merged;
		end
	end

	assign fill.valid = (state_q == S_FILL);
	assign fill.addr  = fill_q.addr;
	assign fill.data  = fill_q.data;

endmodule

`default_nettype wire

// ==== rtl/fill_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module fill_arbiter (
	input  logic             clk,
	input  logic             rst_n,
	fill_if.sink             rd_fill,
	fill_if.sink             wr_fill,
	output logic             out_valid_o,
	input  logic             out_ready_i,
	output cache_pkg::fill_t out_fill_o
);

	logic gnt_wr;      // high when the write path owns the output
	logic rr_wr_q;     // favoured path when both offer a fill
	logic lock_q;
	logic lock_wr_q;
	logic out_fire;

	always_comb begin
		if (lock_q) begin
			gnt_wr = lock_wr_q;   // a stalled fill keeps the output until it is taken
		end else if (rd_fill.valid && wr_fill.valid) begin
			gnt_wr = rr_wr_q;
		end else begin
			gnt_wr = wr_fill.valid;
		end
	end

	always_comb begin
		if (gnt_wr) begin
			out_valid_o     = wr_fill.valid;
			out_fill_o.addr = wr_fill.addr;
			out_fill_o.data = wr_fill.data;
		end else begin
			out_valid_o     = rd_fill.valid;
			out_fill_o.addr = rd_fill.addr;
			out_fill_o.data = rd_fill.data;
		end
	end

	assign rd_fill.ready = out_ready_i && !gnt_wr;
	assign wr_fill.ready = out_ready_i && gnt_wr;
	assign out_fire      = out_valid_o && out_ready_i;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rr_wr_q   <= 1'b0;
			lock_q    <= 1'b0;
			lock_wr_q <= 1'b0;
		end else begin
			lock_q    <= out_valid_o && !out_ready_i;
			lock_wr_q <= gnt_wr;
			if (out_fire && (gnt_wr == rr_wr_q)) begin
				rr_wr_q <= !rr_wr_q;   // hand the priority over once the favourite is served
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/miss_fill_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module miss_fill_top (
	input  logic             clk,
	input  logic             rst_n,
	// read misses
	input  logic             rd_miss_valid_i,
	output logic             rd_miss_ready_o,
	input  cache_pkg::addr_t rd_miss_addr_i,
	input  cxl_pkg::tid_t    rd_miss_tid_i,
	// write misses
	input  logic             wr_miss_valid_i,
	output logic             wr_miss_ready_o,
	input  cache_pkg::addr_t wr_miss_addr_i,
	input  cache_pkg::line_t wr_miss_data_i,
	input  cache_pkg::strb_t wr_miss_strb_i,
	// completions from the link, in request order per channel
	input  logic             rd_rsp_valid_i,
	output logic             rd_rsp_ready_o,
	input  cache_pkg::line_t rd_rsp_data_i,
	input  logic             wr_rsp_valid_i,
	output logic             wr_rsp_ready_o,
	input  cache_pkg::line_t wr_rsp_data_i,
	// cache fill port
	output logic             fill_valid_o,
	input  logic             fill_ready_i,
	output cache_pkg::addr_t fill_addr_o,
	output cache_pkg::line_t fill_data_o,
	// reorder buffer write port
	output logic             rob_we_o,
	input  logic             rob_full_i,
	output cxl_pkg::tid_t    rob_tid_o,
	output cache_pkg::line_t rob_data_o
);
	import cache_pkg::*;
	import cxl_pkg::*;

	rd_miss_t   rd_miss;
	rd_miss_t   rd_q_data;
	logic       rd_q_pop;
	logic       rd_q_empty;
	wr_miss_t   wr_miss;
	wr_miss_t   wr_q_data;
	logic       wr_q_pop;
	logic       wr_q_empty;
	fill_t      fill_out;
	rob_entry_t rob_entry;

	fill_if rd_fill_bus ();
	fill_if wr_fill_bus ();

	assign rd_miss.addr = rd_miss_addr_i;
	assign rd_miss.tid  = rd_miss_tid_i;
	assign wr_miss.addr = wr_miss_addr_i;
	assign wr_miss.data = wr_miss_data_i;
	assign wr_miss.strb = wr_miss_strb_i;

	miss_fifo #(.payload_t(rd_miss_t), .DEPTH(MISS_DEPTH)) i_rd_miss_fifo (
		.clk(clk), .rst_n(rst_n),
		.push_valid_i(rd_miss_valid_i), .push_ready_o(rd_miss_ready_o), .push_data_i(rd_miss),
		.pop_i(rd_q_pop), .empty_o(rd_q_empty), .pop_data_o(rd_q_data)
	);

	miss_fifo #(.payload_t(wr_miss_t), .DEPTH(MISS_DEPTH)) i_wr_miss_fifo (
		.clk(clk), .rst_n(rst_n),
		.push_valid_i(wr_miss_valid_i), .push_ready_o(wr_miss_ready_o), .push_data_i(wr_miss),
		.pop_i(wr_q_pop), .empty_o(wr_q_empty), .pop_data_o(wr_q_data)
	);

	read_miss_handler i_read_miss_handler (
		.clk(clk), .rst_n(rst_n),
		.rsp_valid_i(rd_rsp_valid_i), .rsp_ready_o(rd_rsp_ready_o), .rsp_data_i(rd_rsp_data_i),
		.q_pop_o(rd_q_pop), .q_empty_i(rd_q_empty), .q_data_i(rd_q_data),
		.fill(rd_fill_bus.source),
		.rob_we_o(rob_we_o), .rob_full_i(rob_full_i), .rob_entry_o(rob_entry)
	);

	write_miss_handler i_write_miss_handler (
		.clk(clk), .rst_n(rst_n),
		.rsp_valid_i(wr_rsp_valid_i), .rsp_ready_o(wr_rsp_ready_o), .rsp_data_i(wr_rsp_data_i),
		.q_pop_o(wr_q_pop), .q_empty_i(wr_q_empty), .q_data_i(wr_q_data),
		.fill(wr_fill_bus.source)
	);

	fill_arbiter i_fill_arbiter (
		.clk(clk), .rst_n(rst_n),
		.rd_fill(rd_fill_bus.sink), .wr_fill(wr_fill_bus.sink),
		.out_valid_o(fill_valid_o), .out_ready_i(fill_ready_i), .out_fill_o(fill_out)
	);

	assign fill_addr_o = fill_out.addr;
	assign fill_data_o = fill_out.data;
	assign rob_tid_o   = rob_entry.tid;
	assign rob_data_o  = rob_entry.data;

endmodule

`default_nettype wire

// ==== sim/miss_fill_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module miss_fill_chk (
	input logic             clk,
	input logic             rst_n,
	input logic             fill_valid_i,
	input logic             fill_ready_i,
	input cache_pkg::addr_t fill_addr_i,
	input cache_pkg::line_t fill_data_i,
	input logic             rob_we_i,
	input logic             rob_full_i,
	input logic             rd_rsp_ready_i,
	input logic             wr_rsp_ready_i
);

	// an offered fill may not change or disappear before the cache takes it
	property fill_held_p;
		@(posedge clk) disable iff (!rst_n)
		fill_valid_i && !fill_ready_i |=>
			fill_valid_i && $stable(fill_addr_i) && $stable(fill_data_i);
	endproperty

	property rob_not_full_p;
		@(posedge clk) disable iff (!rst_n)
		!(rob_we_i && rob_full_i);
	endproperty

	// registers settle one edge into reset
	property quiet_in_reset_p;
		@(posedge clk)
		!rst_n |=> !rd_rsp_ready_i && !wr_rsp_ready_i && !fill_valid_i;
	endproperty

	a_fill_held:      assert property (fill_held_p) else $error("fill dropped or changed while stalled");
	a_rob_not_full:   assert property (rob_not_full_p) else $error("ROB write while full");
	a_quiet_in_reset: assert property (quiet_in_reset_p) else $error("handshake active in reset");

endmodule

`default_nettype wire

// ==== sim/miss_fill_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module miss_fill_tb;
	import cache_pkg::*;
	import cxl_pkg::*;

	localparam int N_RD    = 48;
	localparam int N_WR    = 48;
	localparam int TIMEOUT = 40 * (N_RD + N_WR);   // cycles

	logic  clk;
	logic  rst_n;
	logic  rd_miss_valid_i, rd_miss_ready_o, wr_miss_valid_i, wr_miss_ready_o;
	addr_t rd_miss_addr_i, wr_miss_addr_i, fill_addr_o;
	tid_t  rd_miss_tid_i, rob_tid_o;
	line_t wr_miss_data_i, rd_rsp_data_i, wr_rsp_data_i, fill_data_o, rob_data_o;
	strb_t wr_miss_strb_i;
	logic  rd_rsp_valid_i, rd_rsp_ready_o, wr_rsp_valid_i, wr_rsp_ready_o;
	logic  fill_valid_o, fill_ready_i, rob_we_o, rob_full_i;

	integer     seed;
	int         cycles;
	int         rd_sent;
	int         wr_sent;
	logic       dense;     // offer a miss every cycle
	logic       rsp_en;
	logic       rd_miss_fire, wr_miss_fire, rd_rsp_fire, wr_rsp_fire;
	rd_miss_t   rd_pending[$];   // accepted misses still waiting for a completion
	wr_miss_t   wr_pending[$];
	fill_t      exp_rd_fill[$];
	fill_t      exp_wr_fill[$];
	rob_entry_t exp_rob[$];

	miss_fill_top i_miss_fill_top (.*);

	bind miss_fill_top miss_fill_chk i_miss_fill_chk (
		.clk(clk), .rst_n(rst_n),
		.fill_valid_i(fill_valid_o), .fill_ready_i(fill_ready_i),
		.fill_addr_i(fill_addr_o), .fill_data_i(fill_data_o),
		.rob_we_i(rob_we_o), .rob_full_i(rob_full_i),
		.rd_rsp_ready_i(rd_rsp_ready_o), .wr_rsp_ready_i(wr_rsp_ready_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// failure reporting and compare tasks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic stop_with_failure();
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_error(input string why);
		$display("ERROR at %0t: %s", $time, why);
		stop_with_failure();
	endtask

	task automatic check_fill(input string name, input fill_t got, input fill_t exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_rob(input string name, input rob_entry_t got, input rob_entry_t exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s: got %b, expected %b", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	// each byte lane takes the write data where its strobe is set
	function automatic line_t merge_model(input line_t mem_line, input wr_miss_t m);
		line_t mask;
		for (int i = 0; i < LINE_W; i++) begin
			mask[i] = m.strb[i / (LINE_W / STRB_W)];
		end
		return (m.data & mask) | (mem_line & ~mask);
	endfunction

	function automatic logic traffic_drained();
		return rd_sent == N_RD && wr_sent == N_WR && !rd_miss_valid_i && !wr_miss_valid_i
			&& !rd_rsp_valid_i && !wr_rsp_valid_i && rd_pending.size() == 0
			&& wr_pending.size() == 0 && exp_rd_fill.size() == 0
			&& exp_wr_fill.size() == 0 && exp_rob.size() == 0;
	endfunction

	// called on each falling edge and holds every valid until its transfer
	task automatic drive_cycle();
		logic [31:0] rnd;
		if (!rd_miss_valid_i || rd_miss_fire) begin
			rd_miss_valid_i = 1'b0;
			if (rd_sent < N_RD && (dense || ($random(seed) & 3) != 0)) begin
				rnd             = $random(seed);
				rd_miss_valid_i = 1'b1;
				rd_miss_addr_i  = {1'b0, rnd[30:0]};   // bit 31 clear marks the read path
				rd_miss_tid_i   = rnd[31:28];
				rd_sent++;
			end
		end
		if (!wr_miss_valid_i || wr_miss_fire) begin
			wr_miss_valid_i = 1'b0;
			if (wr_sent < N_WR && (dense || ($random(seed) & 3) != 0)) begin
				rnd             = $random(seed);
				wr_miss_valid_i = 1'b1;
				wr_miss_addr_i  = {1'b1, rnd[30:0]};
				wr_miss_data_i  = {$random(seed), $random(seed)};
				rnd             = $random(seed);
				wr_miss_strb_i  = rnd[7:0];
				wr_sent++;
			end
		end
		if (!rd_rsp_valid_i || rd_rsp_fire) begin
			rd_rsp_valid_i = 1'b0;
			if (rsp_en && rd_pending.size() > 0 && ($random(seed) & 1) != 0) begin
				rd_rsp_valid_i = 1'b1;
				rd_rsp_data_i  = {$random(seed), $random(seed)};
			end
		end
		if (!wr_rsp_valid_i || wr_rsp_fire) begin
			wr_rsp_valid_i = 1'b0;
			if (rsp_en && wr_pending.size() > 0 && ($random(seed) & 1) != 0) begin
				wr_rsp_valid_i = 1'b1;
				wr_rsp_data_i  = {$random(seed), $random(seed)};
			end
		end
		rnd          = $random(seed);
		fill_ready_i = (rnd[1:0] != 2'b00);
		rob_full_i   = (rnd[3:2] == 2'b00);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model updated from the transfers seen at each rising edge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge clk) begin : monitor
		fill_t      got_fill;
		rob_entry_t got_rob;
		rd_miss_t   rm;
		wr_miss_t   wm;
		rd_miss_fire = rd_miss_valid_i && rd_miss_ready_o;
		wr_miss_fire = wr_miss_valid_i && wr_miss_ready_o;
		rd_rsp_fire  = rd_rsp_valid_i && rd_rsp_ready_o;
		wr_rsp_fire  = wr_rsp_valid_i && wr_rsp_ready_o;
		if (rst_n) begin
			// queue occupancy equals the accepted misses not yet answered
			compare_flag("rd_miss_ready_o", rd_miss_ready_o, rd_pending.size() != MISS_DEPTH);
			compare_flag("wr_miss_ready_o", wr_miss_ready_o, wr_pending.size() != MISS_DEPTH);
			if (rd_rsp_fire) begin
				rm = rd_pending.pop_front();
				exp_rd_fill.push_back({rm.addr, rd_rsp_data_i});
				exp_rob.push_back({rm.tid, rd_rsp_data_i});
			end
			if (wr_rsp_fire) begin
				wm = wr_pending.pop_front();
				exp_wr_fill.push_back({wm.addr, merge_model(wr_rsp_data_i, wm)});
			end
			if (rd_miss_fire) begin
				rd_pending.push_back({rd_miss_addr_i, rd_miss_tid_i});
			end
			if (wr_miss_fire) begin
				wr_pending.push_back({wr_miss_addr_i, wr_miss_data_i, wr_miss_strb_i});
			end
			if (fill_valid_o && fill_ready_i) begin
				got_fill = {fill_addr_o, fill_data_o};
				if (fill_addr_o[31] && exp_wr_fill.size() == 0) begin
					report_error("write fill seen with no write completion behind it");
				end else if (!fill_addr_o[31] && exp_rd_fill.size() == 0) begin
					report_error("read fill seen with no read completion behind it");
				end else if (fill_addr_o[31]) begin
					check_fill("{fill_addr_o, fill_data_o} write path", got_fill,
						exp_wr_fill.pop_front());
				end else begin
					check_fill("{fill_addr_o, fill_data_o} read path", got_fill,
						exp_rd_fill.pop_front());
				end
			end
			if (rob_we_o && rob_full_i) begin
				report_error("ROB written while rob_full_i was high");
			end else if (rob_we_o && exp_rob.size() == 0) begin
				report_error("ROB write seen with no read completion behind it");
			end else if (rob_we_o) begin
				got_rob = {rob_tid_o, rob_data_o};
				check_rob("{rob_tid_o, rob_data_o}", got_rob, exp_rob.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT) begin
			report_error("timeout, the miss traffic did not drain in time");
		end
	end

	initial begin
		seed            = 32'h2c58;
		cycles          = 0;
		rd_sent         = 0;
		wr_sent         = 0;
		dense           = 1'b1;
		rsp_en          = 1'b0;
		rst_n           = 1'b0;
		rd_miss_valid_i = 1'b0;
		rd_miss_addr_i  = '0;
		rd_miss_tid_i   = '0;
		wr_miss_valid_i = 1'b0;
		wr_miss_addr_i  = '0;
		wr_miss_data_i  = '0;
		wr_miss_strb_i  = '0;
		rd_rsp_valid_i  = 1'b0;
		rd_rsp_data_i   = '0;
		wr_rsp_valid_i  = 1'b0;
		wr_rsp_data_i   = '0;
		fill_ready_i    = 1'b0;
		rob_full_i      = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		compare_flag("fill_valid_o", fill_valid_o, 1'b0);
		compare_flag("rob_we_o", rob_we_o, 1'b0);
		compare_flag("rd_rsp_ready_o", rd_rsp_ready_o, 1'b0);
		compare_flag("wr_rsp_ready_o", wr_rsp_ready_o, 1'b0);
		compare_flag("rd_miss_ready_o", rd_miss_ready_o, 1'b1);
		compare_flag("wr_miss_ready_o", wr_miss_ready_o, 1'b1);

		// fill both queues with no completions
		repeat (MISS_DEPTH + 4) begin
			@(negedge clk);
			drive_cycle();
		end
		@(negedge clk);
		if (rd_pending.size() != MISS_DEPTH || wr_pending.size() != MISS_DEPTH) begin
			report_error("a miss queue did not take exactly MISS_DEPTH entries");
		end
		compare_flag("rd_miss_ready_o", rd_miss_ready_o, 1'b0);
		compare_flag("wr_miss_ready_o", wr_miss_ready_o, 1'b0);

		dense  = 1'b0;
		rsp_en = 1'b1;
		while (!traffic_drained()) begin
			@(negedge clk);
			drive_cycle();
		end
		if (!fill_valid_o && !rob_we_o) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			report_error("fill or ROB write still active after all traffic drained");
		end
	end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/cache_pkg.sv
rtl/cxl_pkg.sv
rtl/fill_if.sv
rtl/miss_fifo.sv
rtl/read_miss_handler.sv
rtl/write_miss_handler.sv
rtl/fill_arbiter.sv
rtl/miss_fill_top.sv
sim/miss_fill_chk.sv
sim/miss_fill_tb.sv

// ==== Makefile ====
# Verilator build and run of the miss-fill testbench

VERILATOR ?= verilator
TOP       ?= miss_fill_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "test failed"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "no result in $(LOG)"; exit 1)
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
